/* files.f */
+incdir+.
cpuPkg.sv
registerFile.sv
selectEncode.sv
conditionLogic.sv
alu.sv
dataPath.sv
dataPathTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dataPathTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard *.sv) $(wildcard *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dataPathVectors.txt */
// kind instruction seed initialPc expected
// kind 1 is a fetch with expected cSign, kind 2 a full branch with expected final PC
1 08012345 00000000 00000010 00012345
1 1207FFFF 00000000 00000020 FFFFFFFF
1 68C40000 00000000 7FFFFFFF FFFC0000
1 A003FFFF 00000000 FFFFFFFF 0003FFFF
2 93C00010 00000000 00000100 00000111
2 9007FFF0 00000005 00000200 00000201
2 93CFFFF0 00001234 00000300 000002F1
2 90080020 00000000 00000400 00000401
2 93D00004 7FFFFFFF 00000500 00000505
2 90100004 00000000 00000600 00000601
2 93D00004 80000000 00000700 00000701
2 93DC0000 FFFFFFFF 00100000 000C0001
2 901BFFFF 7FFFFFFF 00000800 00000801
2 90180001 80000001 FFFFFFF0 FFFFFFF2

/* dataPathTb.sv */
`timescale 1ns/1ps
`include "cpuParams.svh"

module dataPathTb;

    import cpuPkg::*;

    localparam int ClockPeriod = 8;
    localparam int MaxVectors  = 32;
    localparam int RaShift     = `RA_MSB - 3;
    localparam int RbShift     = `RB_MSB - 3;
    localparam int RcShift     = `RC_MSB - 3;

    logic                   clock;
    logic                   arstN;
    controlStrobes          ctrl;
    aluOp                   op;
    logic [`DATA_WIDTH-1:0] mdataIn;
    logic [`DATA_WIDTH-1:0] marOut;
    logic [`DATA_WIDTH-1:0] mdrOut;
    logic [`DATA_WIDTH-1:0] busOut;
    logic                   conFlag;

    logic [`DATA_WIDTH-1:0] vectorMem [5*MaxVectors];
    logic [`DATA_WIDTH-1:0] regSeeds [`REG_COUNT];
    logic [31:0]            lfsrState = 32'h98c6_7d2e;
    int                     vectorCount = 0;
    bit                     vectorsReady = 1'b0;
    int                     errorCount = 0;
    int                     testCount = 0;
    int                     failedTests = 0;
    int                     errorsAtTestStart = 0;

    dataPath UUT (
        .clock   (clock),
        .arstN   (arstN),
        .ctrl    (ctrl),
        .op      (op),
        .mdataIn (mdataIn),
        .marOut  (marOut),
        .mdrOut  (mdrOut),
        .busOut  (busOut),
        .conFlag (conFlag)
    );

    initial begin
        clock = 1'b0;
        forever #(ClockPeriod / 2) clock = ~clock;
    end

    // One bit is taken per step of the x^32 + x^22 + x^2 + x + 1 LFSR
    function automatic logic [31:0] nextRandomWord();
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < 32; i++) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h8020_0003 : lfsrState >> 1;
        end
        return value;
    endfunction

    function automatic logic [31:0] expectedAluResult(input aluOp o, input logic [31:0] y,
                                                      input logic [31:0] b);
        case (o)
            opAdd:   return y + b;
            opSub:   return y - b;
            opAnd:   return y & b;
            opOr:    return y | b;
            opShl:   return y << b[4:0];
            opShr:   return y >> b[4:0];
            opNeg:   return -b;
            default: return ~b;
        endcase
    endfunction

    function automatic logic branchTaken(input logic [1:0] cond, input logic [31:0] value);
        case (cond)
            2'b00:   return value == '0;
            2'b01:   return value != '0;
            2'b10:   return !value[31] && value != '0;
            default: return value[31];
        endcase
    endfunction

    // Sampling happens a quarter period after the falling edge
    task automatic applyStep(input controlStrobes s, input aluOp o = opAdd,
                             input logic [`DATA_WIDTH-1:0] d = '0);
        @(negedge clock);
        ctrl    = s;
        op      = o;
        mdataIn = d;
        #(ClockPeriod / 4);
    endtask

    task automatic loadThroughMdr(input logic [`DATA_WIDTH-1:0] word, input controlStrobes dest);
        applyStep(controlStrobes'{read: '1, default: '0}, opAdd, word);
        dest.mdrOut = 1'b1;
        applyStep(dest);
    endtask

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic reportTest(input string name);
        testCount++;
        if (errorCount != errorsAtTestStart) begin
            failedTests++;
        end
        $display("%-24s %s", name, (errorCount == errorsAtTestStart) ? "ok" : "MISMATCH");
        errorsAtTestStart = errorCount;
    endtask

    initial begin
        logic [`DATA_WIDTH-1:0] yValue, busValue, instr, seed, pcStart, expected;
        aluOp                   aluSel;
        $timeformat(-9, 0, " ns", 0);
        arstN   = 1'b0;
        ctrl    = '0;
        op      = opAdd;
        mdataIn = '0;
        $readmemh("dataPathVectors.txt", vectorMem);
        while (vectorCount < MaxVectors &&
               (vectorMem[5*vectorCount] == 32'd1 || vectorMem[5*vectorCount] == 32'd2)) begin
            vectorCount++;
        end
        vectorsReady = 1'b1;
        repeat (2) @(negedge clock);
        arstN = 1'b1;

        applyStep(controlStrobes'{pcOut: '1, default: '0});
        compareValue("busOut", busOut, '0);
        compareValue("marOut", marOut, '0);
        compareValue("mdrOut", mdrOut, '0);
        compareValue("conFlag", 32'(conFlag), '0);
        reportTest("reset");

        for (int i = 0; i < `REG_COUNT; i++) begin
            regSeeds[i] = nextRandomWord();
            loadThroughMdr(32'(i) << RaShift, controlStrobes'{irIn: '1, default: '0});
            loadThroughMdr(regSeeds[i], controlStrobes'{gra: '1, rIn: '1, default: '0});
        end
        for (int i = 0; i < `REG_COUNT; i++) begin
            loadThroughMdr(32'(i) << RbShift, controlStrobes'{irIn: '1, default: '0});
            applyStep(controlStrobes'{grb: '1, rOut: '1, mdrIn: '1, default: '0});
            compareValue($sformatf("busOut (R%0d)", i), busOut, regSeeds[i]);
            applyStep(controlStrobes'{default: '0});
            compareValue($sformatf("mdrOut (R%0d)", i), mdrOut, regSeeds[i]);
        end
        loadThroughMdr('0, controlStrobes'{irIn: '1, default: '0});
        applyStep(controlStrobes'{grc: '1, baOut: '1, default: '0});
        compareValue("busOut (R0 baOut)", busOut, '0);
        reportTest("register file");

        // R1 carries the bus operand and index 8 stands for the PC increment
        loadThroughMdr((32'd1 << RaShift) | (32'd1 << RcShift),
                       controlStrobes'{irIn: '1, default: '0});
        for (int k = 0; k <= 8; k++) begin
            yValue   = nextRandomWord();
            busValue = nextRandomWord();
            aluSel   = aluOp'((k == 8) ? 7 : k);
            loadThroughMdr(yValue, controlStrobes'{yIn: '1, default: '0});
            loadThroughMdr(busValue, controlStrobes'{gra: '1, rIn: '1, default: '0});
            applyStep(controlStrobes'{grc: '1, rOut: '1, zLowIn: '1, incPc: (k == 8),
                                      default: '0}, aluSel);
            applyStep(controlStrobes'{zLowOut: '1, default: '0});
            compareValue("busOut (Z)", busOut,
                         (k == 8) ? busValue + 1 : expectedAluResult(aluSel, yValue, busValue));
            reportTest((k == 8) ? "alu incPc" : $sformatf("alu %s", aluSel.name()));
        end

        for (int v = 0; v < vectorCount; v++) begin
            instr    = vectorMem[5*v+1];
            seed     = vectorMem[5*v+2];
            pcStart  = vectorMem[5*v+3];
            expected = vectorMem[5*v+4];
            if (vectorMem[5*v] == 32'd2) begin
                loadThroughMdr(instr, controlStrobes'{irIn: '1, default: '0});
                loadThroughMdr(seed, controlStrobes'{gra: '1, rIn: '1, default: '0});
            end
            loadThroughMdr(pcStart, controlStrobes'{pcIn: '1, default: '0});
            applyStep(controlStrobes'{pcOut: '1, marIn: '1, incPc: '1, zLowIn: '1, default: '0});
            applyStep(controlStrobes'{zLowOut: '1, pcIn: '1, read: '1, default: '0}, opAdd, instr);
            applyStep(controlStrobes'{mdrOut: '1, irIn: '1, default: '0});
            if (vectorMem[5*v] == 32'd1) begin
                compareValue("marOut", marOut, pcStart);
                compareValue("mdrOut", mdrOut, instr);
                applyStep(controlStrobes'{pcOut: '1, default: '0});
                compareValue("busOut (PC)", busOut, pcStart + 1);
                applyStep(controlStrobes'{cSignOut: '1, default: '0});
                compareValue("busOut (cSign)", busOut, expected);
                reportTest($sformatf("fetch vector %0d", v));
            end else begin
                applyStep(controlStrobes'{gra: '1, rOut: '1, conIn: '1, default: '0});
                applyStep(controlStrobes'{pcOut: '1, yIn: '1, default: '0});
                applyStep(controlStrobes'{cSignOut: '1, zLowIn: '1, default: '0}, opAdd);
                applyStep(controlStrobes'{zLowOut: '1, pcIn: conFlag, default: '0});
                compareValue("conFlag", 32'(conFlag),
                             32'(branchTaken(instr[`COND_MSB -: 2], seed)));
                applyStep(controlStrobes'{pcOut: '1, default: '0});
                compareValue("busOut (PC)", busOut, expected);
                reportTest($sformatf("branch vector %0d", v));
            end
        end

        $display("Tests run: %0d, failed: %0d, mismatches: %0d",
                 testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        wait (vectorsReady);
        #(vectorCount * 20 * ClockPeriod * 2);
        $display("Timeout: the run did not finish, %0d vectors were loaded", vectorCount);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* dataPath.sv */
`timescale 1ns/1ps
`include "cpuParams.svh"

module dataPath (
    input  logic                   clock,
    input  logic                   arstN,
    input  cpuPkg::controlStrobes  ctrl,
    input  cpuPkg::aluOp           op,
    input  logic [`DATA_WIDTH-1:0] mdataIn,
    output logic [`DATA_WIDTH-1:0] marOut,
    output logic [`DATA_WIDTH-1:0] mdrOut,
    output logic [`DATA_WIDTH-1:0] busOut,
    output logic                   conFlag
);

    import cpuPkg::*;

    logic [`DATA_WIDTH-1:0] pc;
    instrFields             ir;
    logic [`DATA_WIDTH-1:0] mar;
    logic [`DATA_WIDTH-1:0] mdr;
    logic [`DATA_WIDTH-1:0] y;
    logic [`DATA_WIDTH-1:0] zLow;

    logic [`DATA_WIDTH-1:0]        bus;
    logic [`DATA_WIDTH-1:0]        irWord;
    logic [$clog2(`REG_COUNT)-1:0] regIndex;
    logic [`DATA_WIDTH-1:0]        cSign;
    logic [`DATA_WIDTH-1:0]        regData;
    logic [`DATA_WIDTH-1:0]        aluResult;
    branchCond                     cond;

    assign irWord = ir;
    assign cond   = branchCond'(irWord[`COND_MSB -: $bits(branchCond)]);

    // One source drives the bus; the order only matters if the control misbehaves
    always_comb begin
        if (ctrl.mdrOut) begin
            bus = mdr;
        end else if (ctrl.zLowOut) begin
            bus = zLow;
        end else if (ctrl.pcOut) begin
            bus = pc;
        end else if (ctrl.rOut || ctrl.baOut) begin
            bus = regData;
        end else if (ctrl.cSignOut) begin
            bus = cSign;
        end else begin
            bus = '0;
        end
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            pc   <= '0;
            ir   <= '0;
            mar  <= '0;
            mdr  <= '0;
            y    <= '0;
            zLow <= '0;
        end else begin
            if (ctrl.pcIn) begin
                pc <= bus;
            end
            if (ctrl.irIn) begin
                ir <= bus;
            end
            if (ctrl.marIn) begin
                mar <= bus;
            end
            if (ctrl.mdrIn || ctrl.read) begin
                mdr <= ctrl.read ? mdataIn : bus;  // Memory read takes the external word
            end
            if (ctrl.yIn) begin
                y <= bus;
            end
            if (ctrl.zLowIn) begin
                zLow <= aluResult;
            end
        end
    end

    selectEncode selectEncodeInst (
        .ir       (ir),
        .gra      (ctrl.gra),
        .grb      (ctrl.grb),
        .grc      (ctrl.grc),
        .regIndex (regIndex),
        .cSign    (cSign)
    );

    registerFile registerFileInst (
        .clock    (clock),
        .arstN    (arstN),
        .regIndex (regIndex),
        .rIn      (ctrl.rIn),
        .baOut    (ctrl.baOut),
        .busIn    (bus),
        .readData (regData)
    );

    conditionLogic conditionLogicInst (
        .clock   (clock),
        .arstN   (arstN),
        .busIn   (bus),
        .cond    (cond),
        .conIn   (ctrl.conIn),
        .conFlag (conFlag)
    );

    alu aluInst (
        .yValue (y),
        .busIn  (bus),
        .op     (op),
        .incPc  (ctrl.incPc),
        .result (aluResult)
    );

    assign marOut = mar;
    assign mdrOut = mdr;
    assign busOut = bus;

endmodule

/* alu.sv */
`timescale 1ns/1ps
`include "cpuParams.svh"

module alu (
    input  logic [`DATA_WIDTH-1:0] yValue,
    input  logic [`DATA_WIDTH-1:0] busIn,
    input  cpuPkg::aluOp           op,
    input  logic                   incPc,
    output logic [`DATA_WIDTH-1:0] result
);

    import cpuPkg::*;

    localparam int ShiftWidth = $clog2(`DATA_WIDTH);

    logic [ShiftWidth-1:0] shiftCount;

    assign shiftCount = busIn[ShiftWidth-1:0];

    always_comb begin
        if (incPc) begin
            result = busIn + `DATA_WIDTH'(1);  // PC increment overrides the operation
        end else begin
            unique case (op)
                opAdd: begin
                    result = yValue + busIn;
                end
                opSub: begin
                    result = yValue - busIn;
                end
                opAnd: begin
                    result = yValue & busIn;
                end
                opOr: begin
                    result = yValue | busIn;
                end
                opShl: begin
                    result = yValue << shiftCount;
                end
                opShr: begin
                    result = yValue >> shiftCount;  // Logical, zeros shift in
                end
                opNeg: begin
                    result = -busIn;
                end
                opNot: begin
                    result = ~busIn;
                end
                default: begin
                    result = '0;
                end
            endcase
        end
    end

endmodule

/* conditionLogic.sv */
`timescale 1ns/1ps
`include "cpuParams.svh"

module conditionLogic (
    input  logic                   clock,
    input  logic                   arstN,
    input  logic [`DATA_WIDTH-1:0] busIn,
    input  cpuPkg::branchCond      cond,
    input  logic                   conIn,
    output logic                   conFlag
);

    import cpuPkg::*;

    logic isZero;
    logic isNegative;
    logic condTrue;

    assign isZero     = (busIn == '0);
    assign isNegative = busIn[`DATA_WIDTH-1];

    always_comb begin
        unique case (cond)
            condZero:     condTrue = isZero;
            condNonZero:  condTrue = !isZero;
            condPositive: condTrue = !isNegative && !isZero;  // Zero is not positive
            condNegative: condTrue = isNegative;
            default:      condTrue = 1'b0;
        endcase
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            conFlag <= 1'b0;
        end else if (conIn) begin
            conFlag <= condTrue;
        end
    end

endmodule

/* selectEncode.sv */
`timescale 1ns/1ps
`include "cpuParams.svh"

module selectEncode (
    input  cpuPkg::instrFields            ir,
    input  logic                          gra,
    input  logic                          grb,
    input  logic                          grc,
    output logic [$clog2(`REG_COUNT)-1:0] regIndex,
    output logic [`DATA_WIDTH-1:0]        cSign
);

    localparam int IndexWidth = $clog2(`REG_COUNT);

    logic [`DATA_WIDTH-1:0]  irWord;
    logic [`CONST_WIDTH-1:0] constField;

    assign irWord     = ir;
    assign constField = irWord[`CONST_WIDTH-1:0];

    // Only one select is raised per step, so the fields simply OR together
    assign regIndex = ({IndexWidth{gra}} & ir.ra)
                    | ({IndexWidth{grb}} & ir.rb)
                    | ({IndexWidth{grc}} & ir.rc);

    assign cSign = {{(`DATA_WIDTH-`CONST_WIDTH){constField[`CONST_WIDTH-1]}}, constField};

endmodule

/* registerFile.sv */
`timescale 1ns/1ps
`include "cpuParams.svh"

module registerFile (
    input  logic                          clock,
    input  logic                          arstN,
    input  logic [$clog2(`REG_COUNT)-1:0] regIndex,
    input  logic                          rIn,
    input  logic                          baOut,
    input  logic [`DATA_WIDTH-1:0]        busIn,
    output logic [`DATA_WIDTH-1:0]        readData
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rIn) begin
            regs[regIndex] <= busIn;
        end
    end

    // Base-address reads treat R0 as a zero base
    always_comb begin
        if (baOut && regIndex == '0) begin
            readData = '0;
        end else begin
            readData = regs[regIndex];
        end
    end

endmodule

/* cpuPkg.sv */
`include "cpuParams.svh"

package cpuPkg;

    typedef struct packed {
        logic pcOut;
        logic zLowOut;
        logic mdrOut;
        logic rOut;
        logic baOut;
        logic cSignOut;
        logic pcIn;
        logic irIn;
        logic marIn;
        logic mdrIn;
        logic yIn;
        logic zLowIn;
        logic rIn;
        logic conIn;
        logic gra;
        logic grb;
        logic grc;
        logic read;
        logic write;
        logic incPc;
    } controlStrobes;

    // The full constant spans rc and the low field
    typedef struct packed {
        logic [`OPCODE_MSB-`RA_MSB-1:0]            opcode;
        logic [`RA_MSB-`RB_MSB-1:0]                ra;
        logic [`RB_MSB-`RC_MSB-1:0]                rb;
        logic [$clog2(`REG_COUNT)-1:0]             rc;
        logic [`RC_MSB-$clog2(`REG_COUNT):0]       constant;
    } instrFields;

    typedef enum logic [3:0] {
        opAdd = 4'd0,
        opSub = 4'd1,
        opAnd = 4'd2,
        opOr  = 4'd3,
        opShl = 4'd4,
        opShr = 4'd5,
        opNeg = 4'd6,
        opNot = 4'd7
    } aluOp;

    typedef enum logic [1:0] {
        condZero     = 2'b00,
        condNonZero  = 2'b01,
        condPositive = 2'b10,
        condNegative = 2'b11
    } branchCond;

endpackage

/* cpuParams.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Word width of every register and of the bus
`define DATA_WIDTH 32

// General register count, R0 through R15
`define REG_COUNT 16

// Instruction field positions, given by their most significant bit
`define OPCODE_MSB 31
`define RA_MSB 26
`define RB_MSB 22
`define RC_MSB 18

// Constant field sits at the bottom of the word
`define CONST_WIDTH 19

// Branch condition C2 occupies bits 20..19
`define COND_MSB 20

`endif
